//--- src/aes128_encrypt_top.sv
// Top level of the iterative AES-128 encryption core, instantiated as the DUT
`timescale 1ns/10ps
`default_nettype none

module aes128_encrypt_top (
	input  logic               CLK,
	input  logic               RESET,
	input  logic               start,
	input  aes_pkg::aes_req_t  req,
	output logic               busy,
	output logic               done,
	output aes_pkg::block_t    ciphertext
);
	import aes_pkg::*;

	round_ctl_t ctl;
	block_t     round_key;

	aes_round_ctrl u_ctrl (
		.CLK   (CLK),
		.RESET (RESET),
		.start (start),
		.ctl   (ctl),
		.busy  (busy),
		.done  (done)
	);

	aes_key_schedule u_key_schedule (
		.CLK       (CLK),
		.RESET     (RESET),
		.ctl       (ctl),
		.key       (req.key),
		.round_key (round_key)
	);

	aes_state_path u_state_path (
		.CLK       (CLK),
		.RESET     (RESET),
		.ctl       (ctl),
		.plaintext (req.plaintext),
		.round_key (round_key),
		.state     (ciphertext)   // Holds after done until the next load
	);

endmodule

`default_nettype wire

//--- src/aes_key_schedule.sv
// On-the-fly AES-128 key expansion, one round key per step of the round controller
`timescale 1ns/10ps
`default_nettype none

module aes_key_schedule (
	input  logic                 CLK,
	input  logic                 RESET,
	input  aes_pkg::round_ctl_t  ctl,
	input  aes_pkg::block_t      key,
	output aes_pkg::block_t      round_key
);
	import aes_pkg::*;

	block_t key_q;    // Key of the round just applied
	byte_t  rcon_q;   // Constant for the next expansion
	word_t  w0;
	word_t  w1;
	word_t  w2;
	word_t  w3;
	word_t  rot_w;
	word_t  sub_w;
	word_t  g_w;
	block_t next_key;

	assign {w0, w1, w2, w3} = key_q;

	// g function on the last word
	assign rot_w = {w3[23:0], w3[31:24]};

	aes_sub_bytes #(
		.NUM_BYTES (WORD_BYTES)
	) u_sub_word (
		.din  (rot_w),
		.dout (sub_w)
	);

	assign g_w = sub_w ^ {rcon_q, 24'h000000};

	// XOR chain across the words
	always_comb
	begin
		next_key[127:96] = w0 ^ g_w;
		next_key[95:64]  = w1 ^ next_key[127:96];
		next_key[63:32]  = w2 ^ next_key[95:64];
		next_key[31:0]   = w3 ^ next_key[63:32];
	end

	assign round_key = ctl.load ? key : next_key;   // Cipher key for whitening

	always_ff @(posedge CLK or posedge RESET)
	begin
		if (RESET)
		begin
			key_q  <= '0;
			rcon_q <= '0;
		end
		else if (ctl.load)
		begin
			key_q  <= key;
			rcon_q <= RCON_INIT;
		end
		else if (ctl.step)
		begin
			key_q  <= next_key;
			rcon_q <= xtime(rcon_q);
		end
	end

endmodule

`default_nettype wire

//--- src/aes_mix_columns.sv
// MixColumns over the four state columns, applied by the round datapath
`timescale 1ns/10ps
`default_nettype none

module aes_mix_columns (
	input  aes_pkg::block_t din,
	output aes_pkg::block_t dout
);
	import aes_pkg::*;

	always_comb
	begin
		byte_t a0;
		byte_t a1;
		byte_t a2;
		byte_t a3;
		dout = '0;
		for (int c = 0; c < 4; c++)
		begin
			a0 = din[127 - 32*c -: 8];   // Row 0 of column c
			a1 = din[119 - 32*c -: 8];
			a2 = din[111 - 32*c -: 8];
			a3 = din[103 - 32*c -: 8];
			// Circulant matrix 2 3 1 1
			dout[127 - 32*c -: 8] = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
			dout[119 - 32*c -: 8] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
			dout[111 - 32*c -: 8] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
			dout[103 - 32*c -: 8] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
		end
	end

endmodule

`default_nettype wire

//--- src/aes_pkg.sv
// Shared AES-128 types, constants and field helpers, imported by every core module
`default_nettype none

package aes_pkg;

	typedef logic [7:0]   byte_t;
	typedef logic [31:0]  word_t;
	typedef logic [127:0] block_t;   // Byte 0 sits in bits 127:120
	typedef logic [3:0]   round_t;

	localparam int NUM_ROUNDS  = 10;
	localparam int BLOCK_BYTES = 16;
	localparam int WORD_BYTES  = 4;

	localparam byte_t GF_REDUCE = 8'h1b;   // x^8 = x^4 + x^3 + x + 1
	localparam byte_t RCON_INIT = 8'h01;

	typedef struct packed {
		block_t key;
		block_t plaintext;
	} aes_req_t;

	typedef struct packed {
		logic load;   // Initial whitening cycle
		logic step;   // One of the ten round cycles
		logic last;   // Final round without MixColumns
	} round_ctl_t;

	// Multiply by x in GF(2^8)
	function automatic byte_t xtime(input byte_t b);
		return {b[6:0], 1'b0} ^ (b[7] ? GF_REDUCE : 8'h00);
	endfunction

endpackage

`default_nettype wire

//--- src/aes_round_ctrl.sv
// Round sequencer that accepts start, drives load, step and last, and pulses done
`timescale 1ns/10ps
`default_nettype none

module aes_round_ctrl (
	input  logic                 CLK,
	input  logic                 RESET,
	input  logic                 start,
	output aes_pkg::round_ctl_t  ctl,
	output logic                 busy,
	output logic                 done
);
	import aes_pkg::*;

	round_t round;     // Round applied on the coming edge
	logic   last_q;
	logic   accept;

	assign accept = start & ~busy;   // Starts while busy are dropped

	// Load acts on the same edge that samples start
	assign ctl.load = accept;
	assign ctl.step = busy;
	assign ctl.last = last_q;

	always_ff @(posedge CLK or posedge RESET)
	begin
		if (RESET)
		begin
			busy   <= 1'b0;
			last_q <= 1'b0;
			done   <= 1'b0;
			round  <= '0;
		end
		else
		begin
			done <= busy & last_q;   // One cycle after the final round edge
			if (accept)
			begin
				busy   <= 1'b1;
				round  <= round_t'(1);
				last_q <= 1'b0;
			end
			else if (busy)
			begin
				if (last_q)
				begin
					busy   <= 1'b0;
					last_q <= 1'b0;
				end
				else
				begin
					round  <= round_t'(round + 1'b1);
					last_q <= (round == round_t'(NUM_ROUNDS - 1));
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- src/aes_sbox.sv
// Single AES S-box byte computed as a field inverse plus affine map, used by aes_sub_bytes
`timescale 1ns/10ps
`default_nettype none

module aes_sbox (
	input  aes_pkg::byte_t din,
	output aes_pkg::byte_t dout
);
	import aes_pkg::*;

	localparam byte_t AFFINE_C = 8'h63;

	// Shift and add multiply with reduction by the field polynomial
	function automatic byte_t gf_mul(input byte_t a, input byte_t b);
		byte_t p;
		byte_t x;
		p = 8'h00;
		x = a;
		for (int i = 0; i < 8; i++)
		begin
			if (b[i])
				p = p ^ x;
			x = {x[6:0], 1'b0} ^ (x[7] ? GF_REDUCE : 8'h00);
		end
		return p;
	endfunction

	byte_t inv;
	byte_t sq;

	// Inverse as din^254, the product of din^2 up to din^128
	always_comb
	begin
		sq  = din;
		inv = 8'h01;
		for (int k = 1; k < 8; k++)
		begin
			sq  = gf_mul(sq, sq);   // din^(2^k)
			inv = gf_mul(inv, sq);
		end
	end

	// Affine transform written as XOR of left rotations
	assign dout = inv
		^ {inv[6:0], inv[7]}
		^ {inv[5:0], inv[7:6]}
		^ {inv[4:0], inv[7:5]}
		^ {inv[3:0], inv[7:4]}
		^ AFFINE_C;

endmodule

`default_nettype wire

//--- src/aes_state_path.sv
// Cipher state register with initial whitening and one full round per step
`timescale 1ns/10ps
`default_nettype none

module aes_state_path (
	input  logic                 CLK,
	input  logic                 RESET,
	input  aes_pkg::round_ctl_t  ctl,
	input  aes_pkg::block_t      plaintext,
	input  aes_pkg::block_t      round_key,
	output aes_pkg::block_t      state
);
	import aes_pkg::*;

	block_t state_q;
	block_t sb;
	block_t sr;
	block_t mc;
	block_t rnd;

	aes_sub_bytes #(
		.NUM_BYTES (BLOCK_BYTES)
	) u_sub_bytes (
		.din  (state_q),
		.dout (sb)
	);

	// ShiftRows moves byte r+4c from column (c+r) mod 4
	always_comb
	begin
		sr = '0;
		for (int i = 0; i < BLOCK_BYTES; i++)
			sr[127 - 8*i -: 8] = sb[127 - 8*((((i / 4) + (i % 4)) % 4) * 4 + (i % 4)) -: 8];
	end

	aes_mix_columns u_mix_columns (
		.din  (sr),
		.dout (mc)
	);

	assign rnd = (ctl.last ? sr : mc) ^ round_key;   // Final round skips MixColumns

	always_ff @(posedge CLK or posedge RESET)
	begin
		if (RESET)
			state_q <= '0;
		else if (ctl.load)
			state_q <= plaintext ^ round_key;   // Initial AddRoundKey
		else if (ctl.step)
			state_q <= rnd;
	end

	assign state = state_q;

endmodule

`default_nettype wire

//--- src/aes_sub_bytes.sv
// SubBytes layer of NUM_BYTES independent S-boxes, sized by the instantiating module
`timescale 1ns/10ps
`default_nettype none

module aes_sub_bytes #(
	parameter int NUM_BYTES = 16
) (
	input  aes_pkg::byte_t [NUM_BYTES-1:0] din,
	output aes_pkg::byte_t [NUM_BYTES-1:0] dout
);

	genvar i;
	generate
		for (i = 0; i < NUM_BYTES; i++)
		begin : g_sbox
			aes_sbox u_sbox (
				.din  (din[i]),
				.dout (dout[i])
			);
		end
	endgenerate

endmodule

`default_nettype wire

//--- tb.f
src/aes_pkg.sv
src/aes_sbox.sv
src/aes_sub_bytes.sv
src/aes_mix_columns.sv
src/aes_round_ctrl.sv
src/aes_key_schedule.sv
src/aes_state_path.sv
src/aes128_encrypt_top.sv
verif/aes_tb_clock.sv
verif/aes_tb.sv

//--- verif/aes_tb.sv
// Self-checking testbench for the AES-128 core, the simulation top when compiled with tb.f
`timescale 1ns/10ps
`default_nettype none

module aes_tb;
	import aes_pkg::*;

	localparam int     NUM_RANDOM   = 40;
	localparam int     NUM_STARTS   = NUM_RANDOM + 5;   // All start strobes including the ignored one
	localparam int     RESET_CYCLES = 3;
	localparam int     TIMEOUT      = NUM_STARTS * 12 + RESET_CYCLES + 50;
	localparam int     DONE_WAIT    = 20;
	localparam byte_t  AFFINE_C     = 8'h63;
	localparam block_t KAT_KEY      = 128'h000102030405060708090a0b0c0d0e0f;   // FIPS-197 C.1
	localparam block_t KAT_PT       = 128'h00112233445566778899aabbccddeeff;
	localparam block_t KAT_CT       = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

	logic        CLK;
	logic        por_reset;
	logic        abort_reset;
	logic        start;
	aes_req_t    req;
	logic        busy;
	logic        done;
	block_t      ciphertext;
	byte_t       sbox_tab [0:255];   // Reference S-box
	string       test_name;
	int          test_errors  = 0;
	int          total_errors = 0;
	int          tests_run    = 0;
	int          tests_failed = 0;
	int          cycle_count  = 0;

	aes_tb_clock #(
		.PERIOD_NS    (40),
		.RESET_CYCLES (RESET_CYCLES)
	) u_clock (
		.CLK   (CLK),
		.RESET (por_reset)
	);

	aes128_encrypt_top UUT (
		.CLK        (CLK),
		.RESET      (por_reset | abort_reset),
		.start      (start),
		.req        (req),
		.busy       (busy),
		.done       (done),
		.ciphertext (ciphertext)
	);

	always @(posedge CLK)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT)
		begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT);
			$display("Something failed");
			$finish;
		end
	end

	function automatic byte_t gf_mult(input byte_t a, input byte_t b);
		byte_t prod;
		byte_t x;
		prod = 8'h00;
		x    = a;
		for (int i = 0; i < 8; i++)
		begin
			prod = b[i] ? prod ^ x : prod;
			x    = x[7] ? (x << 1) ^ 8'h1b : x << 1;
		end
		return prod;
	endfunction

	// Inverse found by search and then the FIPS-197 affine map bit by bit
	task automatic build_sbox();
		byte_t inv;
		byte_t sb;
		for (int v = 0; v < 256; v++)
		begin
			inv = 8'h00;
			for (int y = 1; y < 256; y++)
				if (gf_mult(8'(v), 8'(y)) == 8'h01)
					inv = 8'(y);
			for (int i = 0; i < 8; i++)
				sb[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^ inv[(i + 6) % 8]
					^ inv[(i + 7) % 8] ^ AFFINE_C[i];
			sbox_tab[v] = sb;
		end
	endtask

	function automatic block_t model_encrypt(input block_t k_in, input block_t p_in);
		byte_t  w [0:175];   // Expanded key of 44 words
		byte_t  s [0:15];    // State indexed by byte r+4c
		byte_t  t [0:15];
		byte_t  tmp [0:3];
		byte_t  rot;
		byte_t  rc;
		block_t ct;
		for (int k = 0; k < 16; k++)
		begin
			w[k] = k_in[127 - 8*k -: 8];
			s[k] = p_in[127 - 8*k -: 8] ^ w[k];
		end
		rc = 8'h01;
		for (int i = 4; i < 44; i++)
		begin
			for (int j = 0; j < 4; j++)
				tmp[j] = w[4*(i - 1) + j];
			if (i % 4 == 0)
			begin
				rot    = tmp[0];   // RotWord, SubWord, Rcon
				tmp[0] = sbox_tab[tmp[1]] ^ rc;
				tmp[1] = sbox_tab[tmp[2]];
				tmp[2] = sbox_tab[tmp[3]];
				tmp[3] = sbox_tab[rot];
				rc     = gf_mult(rc, 8'h02);
			end
			for (int j = 0; j < 4; j++)
				w[4*i + j] = w[4*(i - 4) + j] ^ tmp[j];
		end
		for (int r = 1; r <= 10; r++)
		begin
			for (int k = 0; k < 16; k++)
				t[k] = sbox_tab[s[(k % 4) + 4*(((k / 4) + (k % 4)) % 4)]];
			for (int c = 0; c < 4; c++)
			begin
				if (r < 10)
				begin
					s[4*c]     = gf_mult(t[4*c], 2) ^ gf_mult(t[4*c+1], 3) ^ t[4*c+2] ^ t[4*c+3];
					s[4*c + 1] = t[4*c] ^ gf_mult(t[4*c+1], 2) ^ gf_mult(t[4*c+2], 3) ^ t[4*c+3];
					s[4*c + 2] = t[4*c] ^ t[4*c+1] ^ gf_mult(t[4*c+2], 2) ^ gf_mult(t[4*c+3], 3);
					s[4*c + 3] = gf_mult(t[4*c], 3) ^ t[4*c+1] ^ t[4*c+2] ^ gf_mult(t[4*c+3], 2);
				end
				else
					for (int j = 0; j < 4; j++)
						s[4*c + j] = t[4*c + j];
			end
			for (int k = 0; k < 16; k++)
				s[k] = s[k] ^ w[16*r + k];
		end
		for (int k = 0; k < 16; k++)
			ct[127 - 8*k -: 8] = s[k];
		return ct;
	endfunction

	function automatic block_t random_block();
		return {$urandom(), $urandom(), $urandom(), $urandom()};
	endfunction

	task automatic check_value(input string what, input logic [127:0] exp, input logic [127:0] act);
		assert (act === exp)
		else
		begin
			$display("Fail %s, %s: expected %0h, actual %0h", test_name, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_count(input string what, input int exp, input int act);
		assert (act == exp)
		else
		begin
			$display("Fail %s, %s: expected %0d, actual %0d", test_name, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic open_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic close_test();
		tests_run++;
		total_errors += test_errors;
		if (test_errors == 0)
			$display("Test %s: passed", test_name);
		else
		begin
			$display("Test %s: failed with %0d errors", test_name, test_errors);
			tests_failed++;
		end
	endtask

	// One-cycle start strobe with busy checked between the two edges
	task automatic issue_start(input block_t k_in, input block_t p_in, input logic exp_busy);
		@(posedge CLK);
		start <= 1'b1;
		req   <= '{key: k_in, plaintext: p_in};
		@(negedge CLK);
		check_value("busy at start", exp_busy, busy);
		check_value("done at start", 1'b0, done);   // Previous done lasted one cycle
		@(posedge CLK);
		start <= 1'b0;
	endtask

	task automatic wait_done(output int lat);
		bit seen;
		lat  = 0;
		seen = 1'b0;
		while (!seen && lat < DONE_WAIT)
		begin
			@(posedge CLK);
			lat++;
			@(negedge CLK);
			seen = (done === 1'b1);
		end
		assert (seen)
		else
		begin
			$display("%s: done did not arrive within %0d cycles", test_name, DONE_WAIT);
			test_errors++;
		end
	endtask

	task automatic count_done(input int cycles, output int pulses);
		pulses = 0;
		repeat (cycles)
		begin
			@(negedge CLK);
			if (done !== 1'b0)
				pulses++;
		end
	endtask

	initial
	begin
		block_t k_in;
		block_t p_in;
		block_t exp;
		int     lat;
		int     pulses;
		start       = 1'b0;
		req         = '0;
		abort_reset = 1'b0;
		void'($urandom(32'hd163));
		build_sbox();
		@(negedge por_reset);

		open_test("reset_state");
		repeat (4)
		begin
			@(negedge CLK);
			check_value("busy", 1'b0, busy);
			check_value("done", 1'b0, done);
		end
		close_test();

		open_test("known_answer");
		check_value("model vector", KAT_CT, model_encrypt(KAT_KEY, KAT_PT));
		issue_start(KAT_KEY, KAT_PT, 1'b0);
		wait_done(lat);
		check_value("ciphertext", KAT_CT, ciphertext);
		check_count("latency", NUM_ROUNDS, lat);
		close_test();

		open_test("random_blocks");
		for (int i = 0; i < NUM_RANDOM; i++)
		begin
			k_in = random_block();
			p_in = random_block();
			issue_start(k_in, p_in, 1'b0);   // First edge after the previous done
			wait_done(lat);
			check_value($sformatf("block %0d", i), model_encrypt(k_in, p_in), ciphertext);
			check_count($sformatf("block %0d latency", i), NUM_ROUNDS, lat);
		end
		@(negedge CLK);
		check_value("done after last block", 1'b0, done);
		close_test();

		open_test("start_while_busy");
		k_in = random_block();
		p_in = random_block();
		exp  = model_encrypt(k_in, p_in);
		issue_start(k_in, p_in, 1'b0);
		repeat (2) @(posedge CLK);
		issue_start(random_block(), random_block(), 1'b1);   // Sampled on accept edge + 4
		wait_done(lat);
		check_count("latency", NUM_ROUNDS, lat + 4);
		check_value("ciphertext", exp, ciphertext);
		count_done(12, pulses);
		check_count("extra done pulses", 0, pulses);
		close_test();

		open_test("hold_and_abort");
		k_in = random_block();
		p_in = random_block();
		exp  = model_encrypt(k_in, p_in);
		issue_start(k_in, p_in, 1'b0);
		wait_done(lat);
		repeat (4)
		begin
			@(negedge CLK);
			check_value("held ciphertext", exp, ciphertext);
		end
		issue_start(random_block(), random_block(), 1'b0);
		repeat (4) @(posedge CLK);
		abort_reset <= 1'b1;   // Mid-operation reset
		@(negedge CLK);
		check_value("busy in reset", 1'b0, busy);
		@(posedge CLK);
		abort_reset <= 1'b0;
		count_done(12, pulses);
		check_count("done pulses after abort", 0, pulses);
		check_value("busy after abort", 1'b0, busy);
		check_value("ciphertext after abort", 128'h0, ciphertext);
		close_test();

		$display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, total_errors);
		if (total_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/aes_tb_clock.sv
// Clock and power-on reset source for the AES testbench, instantiated by aes_tb
`timescale 1ns/10ps
`default_nettype none

module aes_tb_clock #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 3
) (
	output logic CLK,
	output logic RESET
);

	initial
	begin
		CLK = 1'b0;
		forever #(PERIOD_NS / 2) CLK = ~CLK;
	end

	initial
	begin
		RESET = 1'b1;
		repeat (RESET_CYCLES) @(posedge CLK);
		RESET <= 1'b0;   // Released on a rising edge
	end

endmodule

`default_nettype wire
